//--- include/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// local history length, also the pattern table index width
`define BP_HIST_BITS 6

// history table index width, 1024 entries
`define BP_BHT_IDX_BITS 10

// lowest pc bit used for the history table index
// word aligned, so the index is pc[11:2]
`define BP_PC_IDX_LSB 2

`endif

//--- rtl/bpPkg.sv
`include "bp_defines.svh"

package bpPkg;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [`BP_HIST_BITS-1:0] hist_t;
    typedef logic [`BP_BHT_IDX_BITS-1:0] bhtIdx_t;

    // upper bit gives the predicted direction
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b11,
        strongTaken    = 2'b10
    } ctrState_e;

    typedef struct packed {
        logic stall;
        logic flush;
    } slotCtl_t;

    // lookup result of one slot, F2 to D
    typedef struct packed {
        logic  predTake;
        hist_t hist;
    } slotPred_t;

    // one slot held in E
    typedef struct packed {
        logic  branch;
        logic  predTake;
        hist_t hist;
    } slotRes_t;

    typedef struct packed {
        logic    valid;
        bhtIdx_t idx;
        logic    taken;
    } histUpd_t;

    // idx is the history carried from the lookup
    typedef struct packed {
        logic  valid;
        hist_t idx;
        logic  taken;
    } ctrUpd_t;

endpackage

//--- rtl/branchDecode.sv
`timescale 1ns/1ps

module branchDecode import bpPkg::*; (
    input  instr_t instr1,
    input  instr_t instr2,
    output logic   branch1,
    output logic   branch2
);

    localparam logic [5:0] RegimmOp = 6'b000001;

    function automatic logic isCondBranch(instr_t instr);
        logic isRegimm;
        logic rtBranch;
        isRegimm = (instr[31:26] == RegimmOp);
        // rt[3:1] of 000 or 001 picks bltz/bgez with link and likely forms
        rtBranch = (instr[19:17] == 3'b000) || (instr[19:17] == 3'b001);
        // beq, bne, blez, bgtz share the upper opcode bits 0001
        return (isRegimm && rtBranch) || (instr[31:28] == 4'b0001);
    endfunction

    assign branch1 = isCondBranch(instr1);
    assign branch2 = isCondBranch(instr2);

endmodule

//--- rtl/historyTable.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module historyTable import bpPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  pc_t      pcF2,
    output hist_t    hist1,
    output hist_t    hist2,
    input  histUpd_t upd1,
    input  histUpd_t upd2
);

    localparam int Depth = 1 << `BP_BHT_IDX_BITS;

    hist_t   histMem [Depth];
    pc_t     pcSlot2;
    bhtIdx_t rdIdx1;
    bhtIdx_t rdIdx2;

    // slot 2 sits one word after slot 1
    assign pcSlot2 = pcF2 + 32'd4;
    assign rdIdx1  = pcF2[`BP_PC_IDX_LSB +: `BP_BHT_IDX_BITS];
    assign rdIdx2  = pcSlot2[`BP_PC_IDX_LSB +: `BP_BHT_IDX_BITS];

    assign hist1 = histMem[rdIdx1];
    assign hist2 = histMem[rdIdx2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                histMem[i] <= '0;
            end
        end else begin
            // newest outcome enters at bit 0
            if (upd1.valid) begin
                histMem[upd1.idx] <= {histMem[upd1.idx][`BP_HIST_BITS-2:0], upd1.taken};
            end
            // the later write lets slot 2 win on a shared entry
            if (upd2.valid) begin
                histMem[upd2.idx] <= {histMem[upd2.idx][`BP_HIST_BITS-2:0], upd2.taken};
            end
        end
    end

endmodule

//--- rtl/patternTable.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module patternTable import bpPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  hist_t   hist1,
    input  hist_t   hist2,
    output logic    predTake1,
    output logic    predTake2,
    input  ctrUpd_t upd1,
    input  ctrUpd_t upd2
);

    localparam int Depth = 1 << `BP_HIST_BITS;

    ctrState_e counters [Depth];

    // one step toward the outcome, saturating at both ends
    function automatic ctrState_e stepCtr(ctrState_e cur, logic taken);
        ctrState_e nxt;
        nxt = cur;
        case (cur)
            strongNotTaken: nxt = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken:   nxt = taken ? weakTaken    : strongNotTaken;
            weakTaken:      nxt = taken ? strongTaken  : weakNotTaken;
            strongTaken:    nxt = taken ? strongTaken  : weakTaken;
            default:        nxt = strongNotTaken;
        endcase
        return nxt;
    endfunction

    // direction is the counter msb
    assign predTake1 = counters[hist1][1];
    assign predTake2 = counters[hist2][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                counters[i] <= strongNotTaken;
            end
        end else begin
            if (upd1.valid) begin
                counters[upd1.idx] <= stepCtr(counters[upd1.idx], upd1.taken);
            end
            // slot 2 overrides slot 1 on the same counter
            if (upd2.valid) begin
                counters[upd2.idx] <= stepCtr(counters[upd2.idx], upd2.taken);
            end
        end
    end

endmodule

//--- rtl/predictStage.sv
`timescale 1ns/1ps

module predictStage import bpPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  slotCtl_t  ctl1,
    input  slotCtl_t  ctl2,
    input  slotPred_t lookup1,
    input  slotPred_t lookup2,
    input  instr_t    instr1,
    input  instr_t    instr2,
    output logic      branch1,
    output logic      branch2,
    output logic      predTake1,
    output logic      predTake2,
    output slotPred_t stage1,
    output slotPred_t stage2
);

    slotCtl_t  ctlArr [2];
    slotPred_t lookupArr [2];
    slotPred_t stageQ [2];

    assign ctlArr[0]    = ctl1;
    assign ctlArr[1]    = ctl2;
    assign lookupArr[0] = lookup1;
    assign lookupArr[1] = lookup2;

    // F2 to D register, flush beats stall
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst || ctlArr[i].flush) begin
                stageQ[i] <= '0;
            end else if (!ctlArr[i].stall) begin
                stageQ[i] <= lookupArr[i];
            end
        end
    end

    branchDecode u_branchDecode (
        .instr1  (instr1),
        .instr2  (instr2),
        .branch1 (branch1),
        .branch2 (branch2)
    );

    assign stage1 = stageQ[0];
    assign stage2 = stageQ[1];

    // only a real branch reports taken
    assign predTake1 = branch1 & stageQ[0].predTake;
    assign predTake2 = branch2 & stageQ[1].predTake;

endmodule

//--- rtl/resolveStage.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module resolveStage import bpPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  slotCtl_t  ctl1,
    input  slotCtl_t  ctl2,
    input  logic      branch1,
    input  logic      branch2,
    input  slotPred_t stage1,
    input  slotPred_t stage2,
    input  pc_t       pcE,
    input  logic      actualTake1,
    input  logic      actualTake2,
    output logic      mispredict1,
    output logic      mispredict2,
    output histUpd_t  histUpd1,
    output histUpd_t  histUpd2,
    output ctrUpd_t   ctrUpd1,
    output ctrUpd_t   ctrUpd2
);

    slotCtl_t ctlArr [2];
    slotRes_t resD [2];
    slotRes_t resQ [2];
    pc_t      slotPc [2];
    logic     actual [2];
    logic     updOk [2];

    assign ctlArr[0] = ctl1;
    assign ctlArr[1] = ctl2;
    assign resD[0]   = '{branch: branch1, predTake: stage1.predTake, hist: stage1.hist};
    assign resD[1]   = '{branch: branch2, predTake: stage2.predTake, hist: stage2.hist};
    assign slotPc[0] = pcE;
    assign slotPc[1] = pcE + 32'd4;
    assign actual[0] = actualTake1;
    assign actual[1] = actualTake2;

    // D to E register, same flush and stall rules as D
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst || ctlArr[i].flush) begin
                resQ[i] <= '0;
            end else if (!ctlArr[i].stall) begin
                resQ[i] <= resD[i];
            end
        end
    end

    // a stalled slot must not train the tables
    assign updOk[0] = resQ[0].branch & ~ctl1.stall;
    assign updOk[1] = resQ[1].branch & ~ctl2.stall;

    assign mispredict1 = resQ[0].branch & (resQ[0].predTake ^ actualTake1);
    assign mispredict2 = resQ[1].branch & (resQ[1].predTake ^ actualTake2);

    assign histUpd1 = '{valid: updOk[0],
                        idx:   slotPc[0][`BP_PC_IDX_LSB +: `BP_BHT_IDX_BITS],
                        taken: actual[0]};
    assign histUpd2 = '{valid: updOk[1],
                        idx:   slotPc[1][`BP_PC_IDX_LSB +: `BP_BHT_IDX_BITS],
                        taken: actual[1]};

    // counter index is the history used at lookup time
    assign ctrUpd1 = '{valid: updOk[0], idx: resQ[0].hist, taken: actual[0]};
    assign ctrUpd2 = '{valid: updOk[1], idx: resQ[1].hist, taken: actual[1]};

endmodule

//--- rtl/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor import bpPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  pc_t      pcF2,
    input  instr_t   instr1D,
    input  instr_t   instr2D,
    input  slotCtl_t ctlD1,
    input  slotCtl_t ctlD2,
    input  slotCtl_t ctlE1,
    input  slotCtl_t ctlE2,
    input  pc_t      pcE,
    input  logic     actualTake1E,
    input  logic     actualTake2E,
    output logic     branch1D,
    output logic     branch2D,
    output logic     predTake1D,
    output logic     predTake2D,
    output logic     mispredict1E,
    output logic     mispredict2E
);

    hist_t     hist1F2;
    hist_t     hist2F2;
    logic      predTake1F2;
    logic      predTake2F2;
    slotPred_t lookup1F2;
    slotPred_t lookup2F2;
    slotPred_t stage1D;
    slotPred_t stage2D;
    histUpd_t  histUpd1E;
    histUpd_t  histUpd2E;
    ctrUpd_t   ctrUpd1E;
    ctrUpd_t   ctrUpd2E;

    assign lookup1F2 = '{predTake: predTake1F2, hist: hist1F2};
    assign lookup2F2 = '{predTake: predTake2F2, hist: hist2F2};

    historyTable u_historyTable (
        .clk   (clk),
        .rst   (rst),
        .pcF2  (pcF2),
        .hist1 (hist1F2),
        .hist2 (hist2F2),
        .upd1  (histUpd1E),
        .upd2  (histUpd2E)
    );

    patternTable u_patternTable (
        .clk       (clk),
        .rst       (rst),
        .hist1     (hist1F2),
        .hist2     (hist2F2),
        .predTake1 (predTake1F2),
        .predTake2 (predTake2F2),
        .upd1      (ctrUpd1E),
        .upd2      (ctrUpd2E)
    );

    predictStage u_predictStage (
        .clk       (clk),
        .rst       (rst),
        .ctl1      (ctlD1),
        .ctl2      (ctlD2),
        .lookup1   (lookup1F2),
        .lookup2   (lookup2F2),
        .instr1    (instr1D),
        .instr2    (instr2D),
        .branch1   (branch1D),
        .branch2   (branch2D),
        .predTake1 (predTake1D),
        .predTake2 (predTake2D),
        .stage1    (stage1D),
        .stage2    (stage2D)
    );

    resolveStage u_resolveStage (
        .clk         (clk),
        .rst         (rst),
        .ctl1        (ctlE1),
        .ctl2        (ctlE2),
        .branch1     (branch1D),
        .branch2     (branch2D),
        .stage1      (stage1D),
        .stage2      (stage2D),
        .pcE         (pcE),
        .actualTake1 (actualTake1E),
        .actualTake2 (actualTake2E),
        .mispredict1 (mispredict1E),
        .mispredict2 (mispredict2E),
        .histUpd1    (histUpd1E),
        .histUpd2    (histUpd2E),
        .ctrUpd1     (ctrUpd1E),
        .ctrUpd2     (ctrUpd2E)
    );

endmodule

//--- verif/bpClockGen.sv
`timescale 1ns/1ps

module bpClockGen (
    output logic clk,
    output logic rst
);

    localparam time HalfPeriod = 50ns;

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // reset spans five rising edges
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verif/branchPredictor_chk.sv
`timescale 1ns/1ps

module branchPredictor_chk import bpPkg::*; (
    input logic     clk,
    input logic     rst,
    input slotCtl_t ctlE1,
    input slotCtl_t ctlE2,
    input logic     predTake1D,
    input logic     predTake2D,
    input logic     mispredict1E,
    input logic     mispredict2E
);

    // number of failed properties so far
    int failures = 0;

    // registers cleared by reset keep D and E quiet
    resetQuiet: assert property (@(posedge clk)
        rst |=> !predTake1D && !predTake2D && !mispredict1E && !mispredict2E)
        else begin
            failures++;
            $error("D or E output active right after a reset edge");
        end

    // flushed E slot is empty in the next cycle
    flushSlot1: assert property (@(posedge clk) disable iff (rst)
        ctlE1.flush |=> !mispredict1E)
        else begin
            failures++;
            $error("slot 1 mispredict after an E flush");
        end

    flushSlot2: assert property (@(posedge clk) disable iff (rst)
        ctlE2.flush |=> !mispredict2E)
        else begin
            failures++;
            $error("slot 2 mispredict after an E flush");
        end

endmodule

//--- verif/branchPredictor_tb.sv
`timescale 1ns/1ps

module branchPredictor_tb import bpPkg::*; ();

    localparam int NumFields = 16;
    localparam int MaxLines  = 64;

    logic        clk;
    logic        rst;
    pc_t         pcF2;
    instr_t      instr1D;
    instr_t      instr2D;
    slotCtl_t    ctlD1;
    slotCtl_t    ctlD2;
    slotCtl_t    ctlE1;
    slotCtl_t    ctlE2;
    pc_t         pcE;
    logic        actualTake1E;
    logic        actualTake2E;
    logic        branch1D;
    logic        branch2D;
    logic        predTake1D;
    logic        predTake2D;
    logic        mispredict1E;
    logic        mispredict2E;
    logic [31:0] pat [MaxLines*NumFields];
    int          numLines;
    int          waitCnt;

    bpClockGen u_clockGen (
        .clk (clk),
        .rst (rst)
    );

    branchPredictor i_branchPredictor (.*);

    bind branchPredictor branchPredictor_chk i_chk (
        .clk          (clk),
        .rst          (rst),
        .ctlE1        (ctlE1),
        .ctlE2        (ctlE2),
        .predTake1D   (predTake1D),
        .predTake2D   (predTake2D),
        .mispredict1E (mispredict1E),
        .mispredict2E (mispredict2E)
    );

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkBit(string name, int line, logic got, logic exp);
        assert (got === exp) else begin
            $display("ERR %s line %0d: got %h, expected %h", name, line, got, exp);
            abortRun("output mismatch");
        end
    endtask

    // ffffffff in the pc column marks an idle lookup
    task automatic driveLine(int n);
        int b;
        b = n * NumFields;
        pcF2         <= (pat[b] == 32'hffffffff) ? ($urandom & 32'hfffffffc) : pat[b];
        instr1D      <= pat[b+1];
        instr2D      <= pat[b+2];
        ctlD1        <= pat[b+3][1:0];
        ctlD2        <= pat[b+4][1:0];
        ctlE1        <= pat[b+5][1:0];
        ctlE2        <= pat[b+6][1:0];
        pcE          <= pat[b+7];
        actualTake1E <= pat[b+8][0];
        actualTake2E <= pat[b+9][0];
    endtask

    task automatic checkLine(int n);
        int b;
        b = n * NumFields;
        checkBit("branch1D", n, branch1D, pat[b+10][0]);
        checkBit("branch2D", n, branch2D, pat[b+11][0]);
        checkBit("predTake1D", n, predTake1D, pat[b+12][0]);
        checkBit("predTake2D", n, predTake2D, pat[b+13][0]);
        checkBit("mispredict1E", n, mispredict1E, pat[b+14][0]);
        checkBit("mispredict2E", n, mispredict2E, pat[b+15][0]);
    endtask

    always @(negedge clk) begin
        if (i_branchPredictor.i_chk.failures != 0) begin
            abortRun("bound checker assertion failed");
        end
    end

    initial begin
        void'($urandom(32'hf02d));
        pcF2         = '0;
        instr1D      = '0;
        instr2D      = '0;
        ctlD1        = '0;
        ctlD2        = '0;
        ctlE1        = '0;
        ctlE2        = '0;
        pcE          = '0;
        actualTake1E = 1'b0;
        actualTake2E = 1'b0;
        $readmemh("verif/branchPredictor_patterns.txt", pat);

        numLines = 0;
        while (numLines < MaxLines && pat[numLines*NumFields] !== 'x) begin
            numLines++;
        end
        if (numLines == 0) begin
            abortRun("pattern file is empty or missing");
        end

        waitCnt = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > 20) begin
                abortRun("reset was never released");
            end
        end

        for (int n = 0; n < numLines; n++) begin
            @(posedge clk);
            driveLine(n);
            @(negedge clk);
            checkLine(n);
        end

        // properties started on the last line complete one edge later
        @(posedge clk);
        @(negedge clk);

        if (i_branchPredictor.i_chk.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            abortRun("bound checker assertion failed");
        end
        $finish;
    end

endmodule

//--- branchPredictor.f
+incdir+include
rtl/bpPkg.sv
rtl/branchDecode.sv
rtl/historyTable.sv
rtl/patternTable.sv
rtl/predictStage.sv
rtl/resolveStage.sv
rtl/branchPredictor.sv
verif/bpClockGen.sv
verif/branchPredictor_chk.sv
verif/branchPredictor_tb.sv

//--- Bender.yml
package:
  name: branchPredictor

sources:
  - include_dirs:
      - include
    files:
      - rtl/bpPkg.sv
      - rtl/branchDecode.sv
      - rtl/historyTable.sv
      - rtl/patternTable.sv
      - rtl/predictStage.sv
      - rtl/resolveStage.sv
      - rtl/branchPredictor.sv
  - target: verif
    include_dirs:
      - include
    files:
      - verif/bpClockGen.sv
      - verif/branchPredictor_chk.sv
      - verif/branchPredictor_tb.sv

//--- verif/branchPredictor_patterns.txt
// pcF2 instr1 instr2 ctlD1 ctlD2 ctlE1 ctlE2 pcE act1 act2
//   then expected branch1 branch2 predTake1 predTake2 mispredict1 mispredict2
ffffffff 10000004 14000000 0 0 1 1 00000000 0 0 1 1 0 0 0 0
ffffffff 18000000 1c000000 0 0 1 1 00000000 0 0 1 1 0 0 0 0
ffffffff 04000000 04010000 0 0 1 1 00000000 0 0 1 1 0 0 0 0
ffffffff 04100000 04030000 0 0 1 1 00000000 0 0 1 1 0 0 0 0
ffffffff 08000000 00851021 0 0 1 1 00000000 0 0 0 0 0 0 0 0
ffffffff 8c820000 04080000 0 0 1 1 00000000 0 0 0 0 0 0 0 0
00000100 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 14000000 10000004 0 0 0 0 00000000 0 0 1 1 0 0 0 0
ffffffff 00000000 00000000 0 0 0 0 00000100 1 0 0 0 0 0 1 0
00000200 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 10000004 00000000 0 0 0 0 00000000 0 0 1 0 0 0 0 0
ffffffff 00000000 00000000 0 0 0 0 00000200 1 0 0 0 0 0 1 0
00000300 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 10000004 00000000 0 0 0 0 00000000 0 0 1 0 0 0 0 0
ffffffff 00000000 00000000 0 0 0 0 00000300 1 0 0 0 0 0 1 0
00000400 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 10000004 00000000 0 0 0 0 00000000 0 0 1 0 1 0 0 0
ffffffff 00000000 00000000 0 0 0 0 00000400 1 0 0 0 0 0 0 0
00000100 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 14000000 10000004 0 0 0 0 00000000 0 0 1 1 0 1 0 0
ffffffff 00000000 00000000 0 0 0 0 00000100 1 1 0 0 0 0 1 0
00000500 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 10000004 10000004 2 1 0 0 00000000 0 0 1 1 1 1 0 0
ffffffff 10000004 10000004 0 0 2 1 00000500 1 1 1 1 1 0 0 0
ffffffff 00000000 00000000 0 0 3 0 00000500 1 0 0 0 0 0 0 0
00000500 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
ffffffff 10000004 10000004 0 0 0 0 00000000 0 0 1 1 1 0 0 0
ffffffff 00000000 00000000 0 0 0 0 00000500 1 0 0 0 0 0 0 0
ffffffff 00000000 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0
